// File: common/ifmap_pkg.sv
package ifmap_pkg;

    // ****************************************
    // sizes
    // ****************************************
    localparam int MAX_SIZE = 38;                   // largest plane edge
    localparam int MAX_K    = 5;                    // largest window edge
    localparam int WIN_BITS = MAX_K * MAX_K;
    localparam int APB_AW   = 4;
    localparam int APB_DW   = 32;

    typedef logic [31:0]         pix_word_t;        // bit 0 is first pixel
    typedef logic [5:0]          coord_t;           // coordinate or plane size
    typedef logic [1:0]          fsize_t;           // 0:K=3 1:K=4 2:K=5
    typedef logic [WIN_BITS-1:0] win_t;             // pixel (r,c) at bit r*K+c
    typedef logic [APB_AW-1:0]   apb_addr_t;
    typedef logic [APB_DW-1:0]   apb_data_t;

    localparam fsize_t FSIZE_BAD = 2'd3;            // refused with slave error

    // ****************************************
    // register map
    // ****************************************
    localparam apb_addr_t REG_CTRL = 4'h0;          // size[5:0], ts[8]
    localparam apb_addr_t REG_DATA = 4'h4;          // 32 pixels
    localparam apb_addr_t REG_REQ  = 4'h8;          // x[5:0] y[13:8] fsize[17:16] ts[24]

    // ****************************************
    // state machines
    // ****************************************
    typedef enum logic {
        FILL_IDLE,
        FILL_BUSY
    } fill_state_t;

    typedef enum logic [1:0] {
        WIN_IDLE,
        WIN_ROWS,
        WIN_PUSH
    } win_state_t;

endpackage

// File: common/ifmap_fill_if.sv
`timescale 1ns/10ps

interface ifmap_fill_if;
    logic                  valid;   // word offered
    logic                  restart; // reset fill pointer of ts
    logic                  ts;
    ifmap_pkg::coord_t     size;    // plane size of ts
    ifmap_pkg::pix_word_t  word;
    logic                  busy;    // store still shifting a word

    modport source (output valid, output restart, output ts, output size, output word,
                    input busy);
    modport sink   (input valid, input restart, input ts, input size, input word,
                    output busy);
endinterface

// File: common/ifmap_win_if.sv
`timescale 1ns/10ps

interface ifmap_win_if #(
    parameter int MAX_SIZE = ifmap_pkg::MAX_SIZE
);
    // request from the register block
    logic               req_valid;
    ifmap_pkg::coord_t  x;
    ifmap_pkg::coord_t  y;
    ifmap_pkg::fsize_t  fsize;
    logic               ts;
    ifmap_pkg::coord_t  size;
    logic               busy;

    // row read port into the store
    ifmap_pkg::coord_t  row_addr;
    logic               row_ts;
    logic               row_rd;
    logic [MAX_SIZE-1:0] row_data;  // one cycle after row_rd

    modport requester (output req_valid, output x, output y, output fsize, output ts,
                       output size, input busy);
    modport reader    (input req_valid, input x, input y, input fsize, input ts,
                       input size, output busy, output row_addr, output row_ts,
                       output row_rd, input row_data);
    modport store     (input row_addr, input row_ts, input row_rd, output row_data);
endinterface

// File: verilog/ifmap_apb_regs.sv
`timescale 1ns/10ps

module ifmap_apb_regs #(
    parameter int MAX_SIZE = ifmap_pkg::MAX_SIZE
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_psel,
    input  logic                 i_penable,
    input  logic                 i_pwrite,
    input  ifmap_pkg::apb_addr_t i_paddr,
    input  ifmap_pkg::apb_data_t i_pwdata,
    output ifmap_pkg::apb_data_t o_prdata,
    output logic                 o_pready,
    output logic                 o_pslverr,
    ifmap_fill_if.source         fill,
    ifmap_win_if.requester       win
);
    ifmap_pkg::coord_t size_q [2];  // plane size per timestep
    ifmap_pkg::coord_t wsize;
    logic              ts_q;        // timestep for DATA writes
    logic              data_sent_q; // word handed to store, waiting for idle
    logic              fill_ts;
    logic              access;
    logic              wr_ctrl;
    logic              wr_data;
    logic              wr_req;
    logic              bad_req;

    assign access  = i_psel && i_penable;
    assign wr_ctrl = access && i_pwrite && (i_paddr == ifmap_pkg::REG_CTRL);
    assign wr_data = access && i_pwrite && (i_paddr == ifmap_pkg::REG_DATA);
    assign wr_req  = access && i_pwrite && (i_paddr == ifmap_pkg::REG_REQ);
    assign bad_req = wr_req && (i_pwdata[17:16] == ifmap_pkg::FSIZE_BAD);

    // sizes above the plane edge are clamped
    assign wsize = (i_pwdata[5:0] > MAX_SIZE) ? ifmap_pkg::coord_t'(MAX_SIZE) : i_pwdata[5:0];

    // ****************************************
    // fill side
    // ****************************************
    assign fill_ts      = wr_ctrl ? i_pwdata[8] : ts_q;
    assign fill.ts      = fill_ts;
    assign fill.restart = wr_ctrl;
    assign fill.size    = size_q[fill_ts];
    assign fill.word    = i_pwdata;
    assign fill.valid   = wr_data && !data_sent_q;  // offered once per transfer

    // ****************************************
    // window request side
    // ****************************************
    assign win.req_valid = wr_req && !bad_req;
    assign win.x         = i_pwdata[5:0];
    assign win.y         = i_pwdata[13:8];
    assign win.fsize     = i_pwdata[17:16];
    assign win.ts        = i_pwdata[24];
    assign win.size      = size_q[i_pwdata[24]];

    always_comb begin
        o_pready = 1'b1;
        if (wr_data) begin
            o_pready = data_sent_q && !fill.busy;  // wait for last pixel
        end else if (win.req_valid) begin
            o_pready = !win.busy;
        end
    end

    assign o_pslverr = bad_req;
    assign o_prdata  = (access && !i_pwrite && (i_paddr == ifmap_pkg::REG_CTRL)) ?
                       {23'b0, ts_q, 2'b0, size_q[ts_q]} : '0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            size_q      <= '{default: '0};
            ts_q        <= 1'b0;
            data_sent_q <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                size_q[i_pwdata[8]] <= wsize;
                ts_q                <= i_pwdata[8];
            end
            if (fill.valid && !fill.busy) begin
                data_sent_q <= 1'b1;
            end else if (wr_data && o_pready) begin
                data_sent_q <= 1'b0;  // transfer done
            end
        end
    end

endmodule

// File: ifmap_mem/ifmap_pixel_store.sv
`timescale 1ns/10ps

module ifmap_pixel_store #(
    parameter int MAX_SIZE = ifmap_pkg::MAX_SIZE
) (
    input  logic       i_clk,
    input  logic       i_rst,
    ifmap_fill_if.sink fill,
    ifmap_win_if.store win
);
    logic [MAX_SIZE-1:0]    plane [2][MAX_SIZE];  // [ts][row] bit = column
    ifmap_pkg::fill_state_t state_q;
    ifmap_pkg::pix_word_t   word_q;
    logic                   ts_q;                 // timestep of word in flight
    logic [4:0]             cnt_q;                // pixel index within word
    ifmap_pkg::coord_t      px_q [2];             // fill pointer per timestep
    ifmap_pkg::coord_t      py_q [2];
    ifmap_pkg::coord_t      last;
    logic                   at_end;
    logic                   take;

    assign last   = fill.size - 1'b1;
    assign at_end = (px_q[ts_q] == last) && (py_q[ts_q] == last);

    // last pixel cycle already frees the port so a new word can follow directly
    assign fill.busy = (state_q == ifmap_pkg::FILL_BUSY) && (cnt_q != 5'd31);
    assign take      = fill.valid && !fill.busy;

    // ****************************************
    // fill FSM and pointers
    // ****************************************
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= ifmap_pkg::FILL_IDLE;
            cnt_q   <= '0;
            px_q    <= '{default: '0};
            py_q    <= '{default: '0};
        end else begin
            if (state_q == ifmap_pkg::FILL_BUSY) begin
                cnt_q <= cnt_q + 1'b1;                 // wraps to 0 after 31
                if (!at_end) begin                     // saturate on last pixel
                    if (px_q[ts_q] == last) begin
                        px_q[ts_q] <= '0;
                        py_q[ts_q] <= py_q[ts_q] + 1'b1;
                    end else begin
                        px_q[ts_q] <= px_q[ts_q] + 1'b1;
                    end
                end
                if ((cnt_q == 5'd31) && !take) begin
                    state_q <= ifmap_pkg::FILL_IDLE;
                end
            end else if (take) begin
                state_q <= ifmap_pkg::FILL_BUSY;
                cnt_q   <= '0;
            end
            if (fill.restart) begin                    // CTRL write wins
                px_q[fill.ts] <= '0;
                py_q[fill.ts] <= '0;
            end
        end
    end

    // ****************************************
    // pixel planes and row read port
    // ****************************************
    always_ff @(posedge i_clk) begin
        if (take) begin
            word_q <= fill.word;
            ts_q   <= fill.ts;
        end
        if ((state_q == ifmap_pkg::FILL_BUSY) &&
            (px_q[ts_q] < MAX_SIZE) && (py_q[ts_q] < MAX_SIZE)) begin
            plane[ts_q][py_q[ts_q]][px_q[ts_q]] <= word_q[cnt_q];
        end
        if (win.row_rd) begin
            win.row_data <= (win.row_addr < MAX_SIZE) ? plane[win.row_ts][win.row_addr] : '0;
        end
    end

endmodule

// File: ifmap_mem/ifmap_window_read.sv
`timescale 1ns/10ps

module ifmap_window_read #(
    parameter int MAX_SIZE = ifmap_pkg::MAX_SIZE
) (
    input  logic            i_clk,
    input  logic            i_rst,
    ifmap_win_if.reader     win,
    output logic            o_push,
    output ifmap_pkg::win_t o_win,
    input  logic            i_full
);
    localparam int K_MAX = ifmap_pkg::MAX_K;

    ifmap_pkg::win_state_t state_q;
    ifmap_pkg::coord_t     x_q;
    ifmap_pkg::coord_t     y_q;
    ifmap_pkg::coord_t     size_q;
    logic                  ts_q;
    logic [2:0]            k_q;       // window edge
    logic [2:0]            r_q;       // row being read
    logic [2:0]            rr_q;      // row whose data is on row_data
    logic                  rd_q;
    logic                  row_ok_q;  // that row lies inside the plane
    logic [6:0]            row_y;
    logic [K_MAX-1:0]      row_bits;
    ifmap_pkg::win_t       win_q;

    assign row_y        = {1'b0, y_q} + 7'(r_q);
    assign win.busy     = (state_q != ifmap_pkg::WIN_IDLE);
    assign win.row_rd   = (state_q == ifmap_pkg::WIN_ROWS) && (r_q < k_q);
    assign win.row_addr = row_y[5:0];
    assign win.row_ts   = ts_q;
    assign o_push       = (state_q == ifmap_pkg::WIN_PUSH) && !i_full;
    assign o_win        = win_q;

    // K pixels starting at column x, clipped at plane size
    always_comb begin
        int unsigned col;
        row_bits = '0;
        for (int c = 0; c < K_MAX; c++) begin
            col = x_q + c;
            if ((c < k_q) && (col < size_q) && (col < MAX_SIZE)) begin
                row_bits[c] = win.row_data[col];
            end
        end
    end

    // ****************************************
    // window FSM
    // ****************************************
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= ifmap_pkg::WIN_IDLE;
            r_q     <= '0;
            rd_q    <= 1'b0;
        end else begin
            rd_q <= win.row_rd;
            case (state_q)
                ifmap_pkg::WIN_IDLE: begin
                    if (win.req_valid) begin
                        state_q <= ifmap_pkg::WIN_ROWS;
                        r_q     <= '0;
                    end
                end
                ifmap_pkg::WIN_ROWS: begin
                    r_q <= r_q + 1'b1;
                    if (r_q == k_q) begin          // last row arrives this cycle
                        state_q <= ifmap_pkg::WIN_PUSH;
                    end
                end
                ifmap_pkg::WIN_PUSH: begin
                    if (!i_full) begin
                        state_q <= ifmap_pkg::WIN_IDLE;
                    end
                end
                default: state_q <= ifmap_pkg::WIN_IDLE;
            endcase
        end
    end

    // request fields and packet assembly
    always_ff @(posedge i_clk) begin
        rr_q     <= r_q;
        row_ok_q <= (row_y < {1'b0, size_q});
        if ((state_q == ifmap_pkg::WIN_IDLE) && win.req_valid) begin
            x_q    <= win.x;
            y_q    <= win.y;
            ts_q   <= win.ts;
            size_q <= win.size;
            k_q    <= 3'(win.fsize) + 3'd3;
            win_q  <= '0;
        end else if (rd_q && row_ok_q) begin
            win_q <= win_q | (ifmap_pkg::win_t'(row_bits) << (5'(rr_q) * 5'(k_q)));
        end
    end

endmodule

// File: verilog/ifmap_win_queue.sv
`timescale 1ns/10ps

module ifmap_win_queue (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_push,
    input  ifmap_pkg::win_t i_win,
    output logic            o_full,
    output logic            o_win_valid,
    output ifmap_pkg::win_t o_win_data,
    input  logic            i_win_ready
);
    ifmap_pkg::win_t mem [2];
    logic            wr_ptr_q;
    logic            rd_ptr_q;
    logic [1:0]      cnt_q;     // 0..2 entries
    logic            do_push;
    logic            do_pop;

    assign o_full      = (cnt_q == 2'd2);
    assign o_win_valid = (cnt_q != 2'd0);
    assign o_win_data  = mem[rd_ptr_q];
    assign do_pop      = o_win_valid && i_win_ready;
    assign do_push     = i_push && (!o_full || do_pop);  // pop frees a slot

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (do_pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            cnt_q <= cnt_q + 2'(do_push) - 2'(do_pop);
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= i_win;
        end
    end

endmodule

// File: verilog/ifmap_top.sv
`timescale 1ns/10ps

module ifmap_top #(
    parameter int MAX_SIZE = ifmap_pkg::MAX_SIZE
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_psel,
    input  logic                 i_penable,
    input  logic                 i_pwrite,
    input  ifmap_pkg::apb_addr_t i_paddr,
    input  ifmap_pkg::apb_data_t i_pwdata,
    output ifmap_pkg::apb_data_t o_prdata,
    output logic                 o_pready,
    output logic                 o_pslverr,
    output logic                 o_win_valid,
    output ifmap_pkg::win_t      o_win_data,
    input  logic                 i_win_ready
);
    logic            push;   // reader into queue
    logic            full;
    ifmap_pkg::win_t win;

    ifmap_fill_if                       fill_if ();
    ifmap_win_if #(.MAX_SIZE(MAX_SIZE)) win_if ();

    // ****************************************
    // APB register block
    // ****************************************
    ifmap_apb_regs #(.MAX_SIZE(MAX_SIZE)) u_regs (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .fill      (fill_if.source),
        .win       (win_if.requester)
    );

    // ****************************************
    // pixel store and window reader
    // ****************************************
    ifmap_pixel_store #(.MAX_SIZE(MAX_SIZE)) u_store (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .fill  (fill_if.sink),
        .win   (win_if.store)
    );

    ifmap_window_read #(.MAX_SIZE(MAX_SIZE)) u_reader (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .win    (win_if.reader),
        .o_push (push),
        .o_win  (win),
        .i_full (full)
    );

    ifmap_win_queue u_queue (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_push      (push),
        .i_win       (win),
        .o_full      (full),
        .o_win_valid (o_win_valid),
        .o_win_data  (o_win_data),
        .i_win_ready (i_win_ready)
    );

endmodule

// File: tb/ifmap_tb.sv
`timescale 1ns/10ps

module ifmap_tb;

    localparam int          MAX_SIZE    = 38;
    localparam int          TAB_LEN     = 13;
    localparam int          CYCLE_LIMIT = TAB_LEN * 64 + 2000;
    localparam logic [31:0] SEED        = 32'h36b7_9fed;

    typedef struct packed {
        ifmap_pkg::coord_t x;
        ifmap_pkg::coord_t y;
        ifmap_pkg::fsize_t fs;
        logic              ts;
        logic [3:0]        stall;   // cycles with ready low after valid
    } req_t;

    // x, y, fsize, ts, stall
    localparam req_t REQ_TAB [TAB_LEN] = '{
        '{6'd1, 6'd1, 2'd0, 1'b0, 4'd0},    // interior, all three K
        '{6'd2, 6'd1, 2'd1, 1'b0, 4'd1},
        '{6'd2, 6'd2, 2'd2, 1'b0, 4'd0},
        '{6'd0, 6'd0, 2'd2, 1'b1, 4'd0},
        '{6'd1, 6'd2, 2'd0, 1'b1, 4'd2},
        '{6'd1, 6'd0, 2'd1, 1'b0, 4'd0},    // same request on both planes
        '{6'd1, 6'd0, 2'd1, 1'b1, 4'd0},
        '{6'd6, 6'd6, 2'd2, 1'b0, 4'd3},    // clipped at the plane edge
        '{6'd4, 6'd3, 2'd2, 1'b1, 4'd0},
        '{6'd7, 6'd0, 2'd0, 1'b0, 4'd1},
        '{6'd5, 6'd5, 2'd1, 1'b1, 4'd0},
        '{6'd3, 6'd7, 2'd1, 1'b0, 4'd0},
        '{6'd0, 6'd4, 2'd0, 1'b1, 4'd2}
    };

    logic                 clk;
    logic                 rst;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    ifmap_pkg::apb_addr_t paddr;
    ifmap_pkg::apb_data_t pwdata;
    ifmap_pkg::apb_data_t prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 win_valid;
    ifmap_pkg::win_t      win_data;
    logic                 win_ready;

    logic [31:0] rng;
    int          cycles;

    // reference planes
    bit   ref_pix [2][MAX_SIZE][MAX_SIZE];
    int   ref_size [2];
    int   ref_px [2];
    int   ref_py [2];
    logic cur_ts;

    ifmap_top #(.MAX_SIZE(MAX_SIZE)) u_ifmap_top (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_psel      (psel),
        .i_penable   (penable),
        .i_pwrite    (pwrite),
        .i_paddr     (paddr),
        .i_pwdata    (pwdata),
        .o_prdata    (prdata),
        .o_pready    (pready),
        .o_pslverr   (pslverr),
        .o_win_valid (win_valid),
        .o_win_data  (win_data),
        .i_win_ready (win_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // ****************************************
    // helpers and reference model
    // ****************************************
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic model_word(input ifmap_pkg::pix_word_t word);
        int s;
        s = ref_size[cur_ts];
        for (int i = 0; i < 32; i++) begin
            ref_pix[cur_ts][ref_py[cur_ts]][ref_px[cur_ts]] = word[i];
            if (!((ref_px[cur_ts] == s - 1) && (ref_py[cur_ts] == s - 1))) begin
                if (ref_px[cur_ts] == s - 1) begin      // next row
                    ref_px[cur_ts] = 0;
                    ref_py[cur_ts] = ref_py[cur_ts] + 1;
                end else begin
                    ref_px[cur_ts] = ref_px[cur_ts] + 1;
                end
            end
        end
    endtask

    function automatic ifmap_pkg::win_t expect_win(input req_t e);
        ifmap_pkg::win_t w;
        int              k;
        int              s;
        w = '0;
        k = int'(e.fs) + 3;
        s = ref_size[e.ts];
        for (int r = 0; r < k; r++) begin
            for (int c = 0; c < k; c++) begin
                if ((int'(e.y) + r < s) && (int'(e.x) + c < s)) begin
                    w[r * k + c] = ref_pix[e.ts][int'(e.y) + r][int'(e.x) + c];
                end
            end
        end
        return w;
    endfunction

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic check_win(input ifmap_pkg::win_t got, input ifmap_pkg::win_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL o_win_data got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_rdata(input ifmap_pkg::apb_data_t got, input ifmap_pkg::apb_data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL o_prdata got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_resp(input logic got_err, input logic exp_err,
                              input int waits, input int lo, input int hi);
        if (got_err !== exp_err) begin
            stop_run($sformatf("FAIL o_pslverr got 0x%h expected 0x%h", got_err, exp_err));
        end
        if ((waits < lo) || (waits > hi)) begin
            stop_run($sformatf("FAIL o_pready wait cycles 0x%h outside 0x%h to 0x%h",
                               waits, lo, hi));
        end
    endtask

    // ****************************************
    // APB and window port drivers
    // ****************************************
    task automatic apb_write(input ifmap_pkg::apb_addr_t addr, input ifmap_pkg::apb_data_t data,
                             output logic err, output int waits);
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;    // setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        err = pslverr;
        @(posedge clk);     // transfer ends on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input ifmap_pkg::apb_addr_t addr,
                            output ifmap_pkg::apb_data_t rdata, output logic err,
                            output int waits);
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;    // setup phase
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_ctrl();
        logic                 err;
        int                   waits;
        ifmap_pkg::apb_data_t rdata;
        ifmap_pkg::apb_data_t exp;
        exp = (ifmap_pkg::apb_data_t'(cur_ts) << 8) |
              ifmap_pkg::apb_data_t'(ref_size[cur_ts]);   // ts at bit 8, size in 5:0
        apb_read(ifmap_pkg::REG_CTRL, rdata, err, waits);
        check_resp(err, 1'b0, waits, 0, 0);
        check_rdata(rdata, exp);
    endtask

    task automatic write_ctrl(input int size, input logic ts);
        logic err;
        int   waits;
        apb_write(ifmap_pkg::REG_CTRL, {23'b0, ts, 2'b0, 6'(size)}, err, waits);
        check_resp(err, 1'b0, waits, 0, 0);
        ref_size[ts] = (size > MAX_SIZE) ? MAX_SIZE : size;
        ref_px[ts]   = 0;
        ref_py[ts]   = 0;
        cur_ts       = ts;
        read_ctrl();
    endtask

    task automatic write_word();
        logic                 err;
        int                   waits;
        ifmap_pkg::apb_data_t word;
        rng  = lcg_next(rng);
        word = rng;
        apb_write(ifmap_pkg::REG_DATA, word, err, waits);
        check_resp(err, 1'b0, waits, 32, 32);   // one pixel per cycle
        model_word(word);
    endtask

    task automatic send_req(input req_t e, input int lo, input int hi);
        logic err;
        int   waits;
        apb_write(ifmap_pkg::REG_REQ, {7'b0, e.ts, 6'b0, e.fs, 2'b0, e.y, 2'b0, e.x},
                  err, waits);
        check_resp(err, (e.fs == 2'd3), waits, lo, hi);
    endtask

    task automatic take_window(input ifmap_pkg::win_t exp, input int stall);
        @(negedge clk);
        while (!win_valid) begin
            @(negedge clk);
        end
        check_win(win_data, exp);
        repeat (stall) begin
            @(negedge clk);
            if (!win_valid) begin
                stop_run("o_win_valid dropped before the handshake");
            end
            check_win(win_data, exp);   // must hold while stalled
        end
        @(posedge clk);
        win_ready <= 1'b1;
        @(posedge clk);
        win_ready <= 1'b0;
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            if (win_valid) begin
                stop_run("a window appeared where none was expected");
            end
        end
    endtask

    task automatic run_table();
        for (int i = 0; i < TAB_LEN; i++) begin
            send_req(REQ_TAB[i], 0, 0);
            take_window(expect_win(REQ_TAB[i]), int'(REQ_TAB[i].stall));
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        req_t bad;
        clk       = 1'b0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        win_ready = 1'b0;
        cycles    = 0;
        rng       = SEED;
        cur_ts    = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!pready || pslverr || win_valid) begin
            stop_run("APB or window outputs are not in their reset state");
        end
        read_ctrl();                // size 0 after reset

        write_ctrl(8, 1'b0);
        write_word();
        write_word();
        write_ctrl(6, 1'b1);
        write_word();
        write_word();               // second word mostly saturates
        run_table();

        // three requests with ready low, drained in order afterwards
        send_req(REQ_TAB[2], 0, 0);
        send_req(REQ_TAB[3], 1, 20);
        send_req(REQ_TAB[8], 1, 20);
        repeat (20) @(posedge clk);
        take_window(expect_win(REQ_TAB[2]), 0);
        take_window(expect_win(REQ_TAB[3]), 0);
        take_window(expect_win(REQ_TAB[8]), 0);
        expect_quiet(16);

        bad = '{6'd1, 6'd1, 2'd3, 1'b0, 4'd0};
        send_req(bad, 0, 0);
        expect_quiet(16);

        write_ctrl(7, 1'b0);        // refill ts 0 from (0,0)
        write_word();
        write_word();
        run_table();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: ifmap_mem.f
common/ifmap_pkg.sv
common/ifmap_fill_if.sv
common/ifmap_win_if.sv
verilog/ifmap_apb_regs.sv
ifmap_mem/ifmap_pixel_store.sv
ifmap_mem/ifmap_window_read.sv
verilog/ifmap_win_queue.sv
verilog/ifmap_top.sv
tb/ifmap_tb.sv

// File: Bender.yml
package:
  name: ifmap_mem

sources:
  - common/ifmap_pkg.sv
  - common/ifmap_fill_if.sv
  - common/ifmap_win_if.sv
  - verilog/ifmap_apb_regs.sv
  - ifmap_mem/ifmap_pixel_store.sv
  - ifmap_mem/ifmap_window_read.sv
  - verilog/ifmap_win_queue.sv
  - verilog/ifmap_top.sv
  - target: test
    files:
      - tb/ifmap_tb.sv
